// ==== src/apb_bridge_pkg.sv ====
// AXI-Lite to APB bridge definitions

package apb_bridge_pkg;

    // AXI-Lite side is fixed at 32 bits
    localparam int axil_data_w = 32;
    localparam int axil_strb_w = axil_data_w / 8;

    // shared by both sides
    localparam int addr_w = 16;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef enum logic {
        st_idle = 1'b0,
        st_data = 1'b1
    } seq_state_e;

    // one granted AXI-Lite transfer
    typedef struct packed {
        logic                   write;
        logic [addr_w-1:0]      addr;
        logic [2:0]             prot;
        logic [axil_data_w-1:0] wdata;
        logic [axil_strb_w-1:0] wstrb;
    } apb_req_t;

    // result once every segment has finished
    typedef struct packed {
        logic                   write;
        logic [axil_data_w-1:0] rdata;
        axi_resp_e              resp;
    } apb_done_t;

endpackage

// ==== src/axil_req_arbiter.sv ====
// AXI-Lite request arbiter

`timescale 1ns/1ps

module axil_req_arbiter (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [apb_bridge_pkg::addr_w-1:0]      awaddr,
    input  logic [2:0]                             awprot,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [apb_bridge_pkg::axil_data_w-1:0] wdata,
    input  logic [apb_bridge_pkg::axil_strb_w-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    input  logic [apb_bridge_pkg::addr_w-1:0]      araddr,
    input  logic [2:0]                             arprot,
    input  logic                                   arvalid,
    output logic                                   arready,

    input  logic                                b_free,
    input  logic                                r_free,
    input  logic                                seq_busy,

    output logic                                req_start,
    output apb_bridge_pkg::apb_req_t            req
);

    logic write_eligible;
    logic read_eligible;
    logic sel_write;
    logic last_read;

    // ready pulses from last cycle block a second grant of the same beat
    assign write_eligible = awvalid && wvalid && b_free && !awready && !wready;
    assign read_eligible  = arvalid && r_free && !arready;

    // alternate when both channels are waiting
    assign sel_write = write_eligible && (!read_eligible || last_read);

    assign req_start = !seq_busy && (write_eligible || read_eligible);

    always_comb begin
        req.write = sel_write;
        req.addr  = sel_write ? awaddr : araddr;
        req.prot  = sel_write ? awprot : arprot;
        req.wdata = wdata;
        // reads carry no strobes
        req.wstrb = sel_write ? wstrb : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            last_read <= 1'b0;
        end else begin
            awready <= req_start && sel_write;
            wready  <= req_start && sel_write;
            arready <= req_start && !sel_write;
            if (req_start) begin
                last_read <= !sel_write;
            end
        end
    end

endmodule

// ==== src/apb_seg_sequencer.sv ====
// APB segment sequencer

`timescale 1ns/1ps

module apb_seg_sequencer #(
    parameter int apb_data_w = 16
) (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                req_start,
    input  apb_bridge_pkg::apb_req_t            req,
    output logic                                seq_busy,

    output logic [apb_bridge_pkg::addr_w-1:0]   paddr,
    output logic [2:0]                          pprot,
    output logic                                psel,
    output logic                                penable,
    output logic                                pwrite,
    output logic [apb_data_w-1:0]               pwdata,
    output logic [apb_data_w/8-1:0]             pstrb,
    input  logic [apb_data_w-1:0]               prdata,
    input  logic                                pready,
    input  logic                                pslverr,

    output logic                                done,
    output apb_bridge_pkg::apb_done_t           done_info
);

    import apb_bridge_pkg::*;

    localparam int apb_strb_w = apb_data_w / 8;
    localparam int seg_count  = axil_strb_w / apb_strb_w;
    localparam int seg_w      = (seg_count > 1) ? $clog2(seg_count) : 1;
    localparam int lane_bits  = $clog2(apb_strb_w);
    localparam logic [addr_w-1:0] addr_mask = ~addr_w'(apb_strb_w - 1);

    seq_state_e state;

    logic [seg_w-1:0]       seg_idx;
    logic [seg_w-1:0]       start_seg;
    logic                   last_seg;
    logic                   access_done;
    logic [axil_data_w-1:0] wdata_buf;
    logic [axil_strb_w-1:0] wstrb_buf;
    logic [axil_data_w-1:0] rdata_buf;
    logic                   err;

    // first segment follows the address lane bits
    assign start_seg = (seg_count > 1) ? req.addr[lane_bits +: seg_w] : '0;
    assign last_seg  = (seg_idx == seg_w'(seg_count - 1));

    assign access_done = psel && penable && pready;

    // busy until the completion has been handed over
    assign seq_busy = (state == st_data) || done;

    assign pwdata = wdata_buf[seg_idx*apb_data_w +: apb_data_w];
    assign pstrb  = wstrb_buf[seg_idx*apb_strb_w +: apb_strb_w];

    always_comb begin
        done_info.write = pwrite;
        done_info.rdata = rdata_buf;
        done_info.resp  = err ? resp_slverr : resp_okay;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            psel    <= 1'b0;
            penable <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_start) begin
                        psel  <= 1'b1;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (!penable) begin
                        // setup phase over
                        penable <= 1'b1;
                    end else if (pready) begin
                        penable <= 1'b0;
                        if (last_seg) begin
                            psel  <= 1'b0;
                            done  <= 1'b1;
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // transfer payload, loaded at the grant
    always_ff @(posedge clk) begin
        if (state == st_idle && req_start) begin
            pwrite    <= req.write;
            paddr     <= req.addr;
            pprot     <= req.prot;
            wdata_buf <= req.wdata;
            wstrb_buf <= req.wstrb;
            seg_idx   <= start_seg;
            rdata_buf <= '0;
            err       <= 1'b0;
        end else if (access_done) begin
            rdata_buf[seg_idx*apb_data_w +: apb_data_w] <= prdata;
            seg_idx <= seg_idx + 1'b1;
            paddr   <= (paddr & addr_mask) + addr_w'(apb_strb_w);
            // sticky over all segments
            if (pslverr) begin
                err <= 1'b1;
            end
        end
    end

endmodule

// ==== src/axil_resp_regs.sv ====
// AXI-Lite response registers

`timescale 1ns/1ps

module axil_resp_regs (
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic                                   done,
    input  apb_bridge_pkg::apb_done_t              done_info,

    output logic                                   bvalid,
    input  logic                                   bready,
    output apb_bridge_pkg::axi_resp_e              bresp,

    output logic                                   rvalid,
    input  logic                                   rready,
    output apb_bridge_pkg::axi_resp_e              rresp,
    output logic [apb_bridge_pkg::axil_data_w-1:0] rdata,

    output logic                                   b_free,
    output logic                                   r_free
);

    // a channel draining this cycle counts as free
    assign b_free = !bvalid || bready;
    assign r_free = !rvalid || rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bready) begin
                bvalid <= 1'b0;
            end
            if (rready) begin
                rvalid <= 1'b0;
            end
            if (done && done_info.write) begin
                bvalid <= 1'b1;
            end
            if (done && !done_info.write) begin
                rvalid <= 1'b1;
            end
        end
    end

    // held until the manager takes them
    always_ff @(posedge clk) begin
        if (done && done_info.write) begin
            bresp <= done_info.resp;
        end
        if (done && !done_info.write) begin
            rresp <= done_info.resp;
            rdata <= done_info.rdata;
        end
    end

endmodule

// ==== src/axil_apb_bridge.sv ====
// AXI-Lite to APB bridge top

`timescale 1ns/1ps

module axil_apb_bridge #(
    parameter int apb_data_w = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,

    // AXI-Lite slave
    input  logic [apb_bridge_pkg::addr_w-1:0]      awaddr,
    input  logic [2:0]                             awprot,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [apb_bridge_pkg::axil_data_w-1:0] wdata,
    input  logic [apb_bridge_pkg::axil_strb_w-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output apb_bridge_pkg::axi_resp_e              bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [apb_bridge_pkg::addr_w-1:0]      araddr,
    input  logic [2:0]                             arprot,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [apb_bridge_pkg::axil_data_w-1:0] rdata,
    output apb_bridge_pkg::axi_resp_e              rresp,
    output logic                                   rvalid,
    input  logic                                   rready,

    // APB master
    output logic [apb_bridge_pkg::addr_w-1:0]      paddr,
    output logic [2:0]                             pprot,
    output logic                                   psel,
    output logic                                   penable,
    output logic                                   pwrite,
    output logic [apb_data_w-1:0]                  pwdata,
    output logic [apb_data_w/8-1:0]                pstrb,
    input  logic [apb_data_w-1:0]                  prdata,
    input  logic                                   pready,
    input  logic                                   pslverr
);

    import apb_bridge_pkg::*;

    logic      req_start;
    apb_req_t  req;
    logic      seq_busy;
    logic      done;
    apb_done_t done_info;
    logic      b_free;
    logic      r_free;

    axil_req_arbiter i_axil_req_arbiter (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awprot   (awprot),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .araddr   (araddr),
        .arprot   (arprot),
        .arvalid  (arvalid),
        .arready  (arready),
        .b_free   (b_free),
        .r_free   (r_free),
        .seq_busy (seq_busy),
        .req_start(req_start),
        .req      (req)
    );

    apb_seg_sequencer #(
        .apb_data_w(apb_data_w)
    ) i_apb_seg_sequencer (
        .clk      (clk),
        .rst      (rst),
        .req_start(req_start),
        .req      (req),
        .seq_busy (seq_busy),
        .paddr    (paddr),
        .pprot    (pprot),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .pstrb    (pstrb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .done     (done),
        .done_info(done_info)
    );

    axil_resp_regs i_axil_resp_regs (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .done_info(done_info),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .rresp    (rresp),
        .rdata    (rdata),
        .b_free   (b_free),
        .r_free   (r_free)
    );

endmodule

// ==== sim/apb_mem_model.sv ====
// APB memory completer

`timescale 1ns/1ps

module apb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] pwdata,
    input  logic [1:0]  pstrb,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam logic [31:0] seed = 32'h52f77b71;

    logic [15:0] mem [0:255];
    logic [31:0] rng;
    logic [1:0]  wait_cnt;
    logic        err_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // bit 12 marks the error window
    assign err_addr = paddr[12];
    assign pready   = psel && penable && (wait_cnt == 2'd0);
    assign pslverr  = pready && err_addr;
    assign prdata   = err_addr ? 16'h0000 : mem[paddr[8:1]];

    always_ff @(posedge clk) begin
        if (rst) begin
            rng      <= seed;
            wait_cnt <= 2'd0;
        end else if (psel && !penable) begin
            // fresh wait count each setup phase
            rng      <= xorshift(rng);
            wait_cnt <= rng[1:0];
        end else if (psel && penable && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // pattern uses every word address bit
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {~8'(i), 8'(i)};
            end
        end else if (pready && pwrite && !err_addr) begin
            if (pstrb[0]) begin
                mem[paddr[8:1]][7:0] <= pwdata[7:0];
            end
            if (pstrb[1]) begin
                mem[paddr[8:1]][15:8] <= pwdata[15:8];
            end
        end
    end

endmodule

// ==== sim/tb_axil_apb_bridge.sv ====
// AXI-Lite to APB bridge testbench

`timescale 1ns/1ps

module tb_axil_apb_bridge;

    import apb_bridge_pkg::*;

    localparam int num_vec        = 15;
    localparam int vec_fields     = 7;
    localparam int reset_cycles   = 5;
    localparam int timeout_cycles = num_vec * 200 + reset_cycles;
    localparam logic [2:0] write_prot = 3'b010;
    localparam logic [2:0] read_prot  = 3'b001;

    logic                   clk;
    logic                   rst;
    logic [addr_w-1:0]      awaddr;
    logic [2:0]             awprot;
    logic                   awvalid;
    logic                   awready;
    logic [axil_data_w-1:0] wdata;
    logic [axil_strb_w-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    axi_resp_e              bresp;
    logic                   bvalid;
    logic                   bready;
    logic [addr_w-1:0]      araddr;
    logic [2:0]             arprot;
    logic                   arvalid;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    axi_resp_e              rresp;
    logic                   rvalid;
    logic                   rready;
    logic [addr_w-1:0]      paddr;
    logic [2:0]             pprot;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [15:0]            pwdata;
    logic [1:0]             pstrb;
    logic [15:0]            prdata;
    logic                   pready;
    logic                   pslverr;

    logic [31:0] vec_mem [0:num_vec*vec_fields-1];
    logic        last_was_write;
    time         aw_time;
    time         ar_time;

    axil_apb_bridge #(
        .apb_data_w(16)
    ) i_axil_apb_bridge (.*);

    apb_mem_model i_apb_mem_model (.*);

    always #50 clk = ~clk;

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: vectors did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp,
                             input int delay, input logic solo);
        logic [1:0] held;
        logic       resend;
        resend = solo && (delay > 0);
        @(negedge clk);
        awaddr  = addr;
        awprot  = write_prot;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!awready);
        aw_time = $time;
        // grant cycle starts the first setup phase
        check("wready", 32'(wready), 32'h1);
        check("psel", 32'(psel), 32'h1);
        check("pwrite", 32'(pwrite), 32'h1);
        check("paddr", 32'(paddr), 32'(addr));
        check("pprot", 32'(pprot), 32'(write_prot));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check("awready", 32'(awready), 32'h0);
        do @(negedge clk); while (!bvalid);
        held = bresp;
        check("bresp", 32'(bresp), 32'(exp_resp));
        // same write again, it has to wait for the B channel to drain
        if (resend) begin
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end
        repeat (delay) begin
            @(negedge clk);
            check("bvalid", 32'(bvalid), 32'h1);
            check("bresp", 32'(bresp), 32'(held));
            if (solo) begin
                check("psel", 32'(psel), 32'h0);
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check("bvalid", 32'(bvalid), 32'h0);
        if (resend) begin
            // taken in the cycle the old response drains
            check("awready", 32'(awready), 32'h1);
            @(negedge clk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            do @(negedge clk); while (!bvalid);
            check("bresp", 32'(bresp), 32'(exp_resp));
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
            check("bvalid", 32'(bvalid), 32'h0);
        end
    endtask

    task automatic axi_read(input logic [addr_w-1:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp, input int delay, input logic solo);
        logic [1:0]  held_resp;
        logic [31:0] held_data;
        logic        resend;
        resend = solo && (delay > 0);
        @(negedge clk);
        araddr  = addr;
        arprot  = read_prot;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        ar_time = $time;
        check("psel", 32'(psel), 32'h1);
        check("pwrite", 32'(pwrite), 32'h0);
        check("paddr", 32'(paddr), 32'(addr));
        check("pprot", 32'(pprot), 32'(read_prot));
        @(negedge clk);
        arvalid = 1'b0;
        check("arready", 32'(arready), 32'h0);
        do @(negedge clk); while (!rvalid);
        held_resp = rresp;
        held_data = rdata;
        check("rresp", 32'(rresp), 32'(exp_resp));
        check("rdata", rdata, exp_data);
        // same read again, it has to wait for the R channel to drain
        if (resend) begin
            arvalid = 1'b1;
        end
        repeat (delay) begin
            @(negedge clk);
            check("rvalid", 32'(rvalid), 32'h1);
            check("rresp", 32'(rresp), 32'(held_resp));
            check("rdata", rdata, held_data);
            if (solo) begin
                check("psel", 32'(psel), 32'h0);
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check("rvalid", 32'(rvalid), 32'h0);
        if (resend) begin
            check("arready", 32'(arready), 32'h1);
            @(negedge clk);
            arvalid = 1'b0;
            do @(negedge clk); while (!rvalid);
            check("rresp", 32'(rresp), 32'(exp_resp));
            check("rdata", rdata, exp_data);
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
            check("rvalid", 32'(rvalid), 32'h0);
        end
    endtask

    initial begin
        int base;
        logic [31:0] op;
        logic [addr_w-1:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        logic [31:0] exp_data;
        logic [1:0] exp_resp;
        int delay;
        clk     = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awprot  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arprot  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        // arbiter comes out of reset treating the last grant as a write
        last_was_write = 1'b1;
        $readmemh("sim/bridge_vectors.hex", vec_mem);
        repeat (reset_cycles) @(negedge clk);
        check("awready", 32'(awready), 32'h0);
        check("wready", 32'(wready), 32'h0);
        check("arready", 32'(arready), 32'h0);
        check("bvalid", 32'(bvalid), 32'h0);
        check("rvalid", 32'(rvalid), 32'h0);
        check("psel", 32'(psel), 32'h0);
        check("penable", 32'(penable), 32'h0);
        rst = 1'b0;
        for (int v = 0; v < num_vec; v++) begin
            base     = v * vec_fields;
            op       = vec_mem[base];
            addr     = vec_mem[base + 1][addr_w-1:0];
            data     = vec_mem[base + 2];
            strb     = vec_mem[base + 3][3:0];
            exp_data = vec_mem[base + 4];
            exp_resp = vec_mem[base + 5][1:0];
            delay    = int'(vec_mem[base + 6]);
            if (op == 32'h0) begin
                axi_write(addr, data, strb, exp_resp, delay, 1'b1);
                last_was_write = 1'b1;
            end else if (op == 32'h1) begin
                axi_read(addr, exp_data, exp_resp, delay, 1'b1);
                last_was_write = 1'b0;
            end else begin
                fork
                    axi_write(addr, data, strb, exp_resp, delay, 1'b0);
                    axi_read(addr, exp_data, exp_resp, delay, 1'b0);
                join
                // write goes first only after a read grant
                check("awready_first", 32'(aw_time < ar_time), 32'(!last_was_write));
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== sim/bridge_vectors.hex ====
// op (0 write, 1 read, 2 write and read together) addr data strb exp_rdata exp_resp delay
// exp_resp 0 okay, 2 slverr; delay counts cycles before bready or rready
1 0010 00000000 0 f609f708 0 0
0 0010 a1b2c3d4 f 00000000 0 0
1 0010 00000000 0 a1b2c3d4 0 0
0 0020 11223344 c 00000000 0 2
1 0020 00000000 0 1122ef10 0 3
0 0030 55667788 6 00000000 0 0
1 0030 00000000 0 e6667718 0 0
0 1040 deadbeef f 00000000 2 1
1 1040 00000000 0 00000000 2 2
1 0040 00000000 0 de21df20 0 0
0 0050 0badf00d f 00000000 0 0
2 0050 12345678 f 0badf00d 0 0
1 0050 00000000 0 12345678 0 0
2 0060 cafe0001 f cafe0001 0 1
1 0060 00000000 0 cafe0001 0 0

// ==== all.f ====
src/apb_bridge_pkg.sv
src/axil_req_arbiter.sv
src/apb_seg_sequencer.sv
src/axil_resp_regs.sv
src/axil_apb_bridge.sv
sim/apb_mem_model.sv
sim/tb_axil_apb_bridge.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_axil_apb_bridge -f all.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log && exit 0 || exit 1
